/* dv/cnn_awp_props.sv */
`timescale 1ns/1ps

module cnn_awp_props (
    input logic                   clk_FAS,
    input logic                   rst,
    input logic                   in_req,
    input logic                   in_ack,
    input logic                   eg_req,
    input logic                   eg_ack,
    input cnn_awp_pkg::trans_eg_t eg_data
);

    ////////////////////
    // Input port
    ////////////////////

    // Ack only answers a request
    a_ack_needs_req: assert property (@(posedge clk_FAS) disable iff (rst)
        $rose(in_ack) |-> $past(in_req))
        else $error("in_ack rose while in_req was low");

    ////////////////////
    // Output port
    ////////////////////

    // Word frozen for the whole req phase
    a_eg_data_stable: assert property (@(posedge clk_FAS) disable iff (rst)
        (eg_req && $past(eg_req)) |-> (eg_data == $past(eg_data)))
        else $error("eg_data changed while eg_req was high");

    // New req only after the previous ack is gone
    a_req_after_ack_low: assert property (@(posedge clk_FAS) disable iff (rst)
        $rose(eg_req) |-> !$past(eg_ack))
        else $error("eg_req rose while eg_ack was high");

    // Both ports quiet right out of reset
    a_reset_quiet: assert property (@(posedge clk_FAS)
        $past(rst) |-> (!in_ack && !eg_req))
        else $error("in_ack or eg_req high in the cycle after rst");

endmodule

/* dv/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD = 10,
    parameter int RST_CYCLES  = 2
) (
    output logic clk_FAS,
    output logic rst
);

    // 20 ns period
    initial begin
        clk_FAS = 1'b0;
        forever #HALF_PERIOD clk_FAS = ~clk_FAS;
    end

    // Reset held over the first rising edges, released just after
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_FAS);
        #1;
        rst = 1'b0;
    end

endmodule

/* dv/tb_cnn_awp.sv */
`timescale 1ns/1ps

module tb_cnn_awp;

    import cnn_awp_pkg::*;

    localparam int NUM_QUADS   = 4;
    localparam int TIMEOUT     = 200;
    localparam int MIX_COUNT   = 48;
    localparam int BURST_COUNT = 24;

    logic      clk_FAS;
    logic      rst;
    logic      in_req;
    trans_in_t in_data;
    logic      in_ack;
    logic      eg_req;
    trans_eg_t eg_data;
    logic      eg_ack;

    // Galois LFSR states, one stream for the source and one for the sink, seed 50
    logic [15:0] src_lfsr;
    logic [15:0] sink_lfsr;
    // Reference model
    pixel_t      model_wt [NUM_QUADS];
    trans_eg_t   exp_q [$];
    seq_t        next_seq;
    int          n_pix_sent;
    int          n_results;
    // Error counts
    int          mismatch_cnt;
    int          timeout_cnt;
    int          fail_cnt;
    bit          src_done;
    bit          abort;

    tb_clock_gen i_tb_clock_gen (
        .clk_FAS (clk_FAS),
        .rst     (rst)
    );

    cnn_layer_accel_awp i_cnn_layer_accel_awp (
        .clk_FAS (clk_FAS),
        .rst     (rst),
        .in_req  (in_req),
        .in_data (in_data),
        .in_ack  (in_ack),
        .eg_req  (eg_req),
        .eg_data (eg_data),
        .eg_ack  (eg_ack)
    );

    bind cnn_layer_accel_awp cnn_awp_props i_cnn_awp_props (
        .clk_FAS (clk_FAS),
        .rst     (rst),
        .in_req  (in_req),
        .in_ack  (in_ack),
        .eg_req  (eg_req),
        .eg_ack  (eg_ack),
        .eg_data (eg_data)
    );

    ////////////////////
    // Random bits
    ////////////////////

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(inout logic [15:0] state, input int nbits,
                             output logic [31:0] val);
        val = '0;
        for (int b = 0; b < nbits; b++) begin
            val   = {val[30:0], state[0]};
            state = lfsr_next(state);
        end
    endtask

    // Inputs move 1 ns after the edge, outputs read there too
    task automatic next_cycle();
        @(posedge clk_FAS);
        #1;
    endtask

    ////////////////////
    // Reference model
    ////////////////////

    task automatic record_accept(input trans_in_t word);
        logic [31:0] acc;
        trans_eg_t   exp_w;
        if (word.kind == KIND_WEIGHT) begin
            for (int q = 0; q < NUM_QUADS; q++) begin
                model_wt[q] = word.lanes[q];
            end
        end else begin
            // Dot product over the quads, wrapped to the cascade width
            acc = '0;
            for (int q = 0; q < NUM_QUADS; q++) begin
                acc = acc + 32'(word.lanes[q]) * 32'(model_wt[q]);
            end
            exp_w.seq = next_seq;
            exp_w.sum = sum_t'(acc);
            exp_q.push_back(exp_w);
            next_seq = next_seq + 1'b1;
            n_pix_sent++;
        end
    endtask

    task automatic check_result();
        trans_eg_t exp_w;
        assert (exp_q.size() != 0) else begin
            $display("Result seq %0d at %0t arrived with no pixel transaction outstanding",
                     eg_data.seq, $time);
            fail_cnt++;
        end
        if (exp_q.size() == 0) begin
            return;
        end
        exp_w = exp_q.pop_front();
        assert (eg_data.seq == exp_w.seq) else begin
            $display("MISMATCH at %0t: eg_data.seq expected %0d got %0d",
                     $time, exp_w.seq, eg_data.seq);
            mismatch_cnt++;
        end
        assert (eg_data.sum == exp_w.sum) else begin
            $display("MISMATCH at %0t: eg_data.sum expected %0d got %0d",
                     $time, exp_w.sum, eg_data.sum);
            mismatch_cnt++;
        end
        n_results++;
    endtask

    ////////////////////
    // Input source
    ////////////////////

    task automatic send_trans(input trans_in_t word);
        int timer;
        in_data = word;
        in_req  = 1'b1;
        timer   = 0;
        while (!in_ack && !abort) begin
            next_cycle();
            timer++;
            if (timer > TIMEOUT) begin
                $display("Timeout at %0t: in_ack never rose for a held request", $time);
                timeout_cnt++;
                abort = 1'b1;
            end
        end
        if (abort) begin
            return;
        end
        // Accepted on this ack
        record_accept(word);
        in_req = 1'b0;
        timer  = 0;
        while (in_ack && !abort) begin
            next_cycle();
            timer++;
            if (timer > TIMEOUT) begin
                $display("Timeout at %0t: in_ack stayed high after in_req fell", $time);
                timeout_cnt++;
                abort = 1'b1;
            end
        end
    endtask

    task automatic run_source(input int count, input bit pixels_only);
        trans_in_t   word;
        logic [31:0] r;
        for (int i = 0; i < count && !abort; i++) begin
            // Weights about one time in eight, always first in the mixed run
            draw_bits(src_lfsr, 3, r);
            if (!pixels_only && (i == 0 || r[2:0] == 3'd0)) begin
                word.kind = KIND_WEIGHT;
            end else begin
                word.kind = KIND_PIXEL;
            end
            for (int q = 0; q < NUM_LANES; q++) begin
                draw_bits(src_lfsr, PIXEL_W, r);
                word.lanes[q] = r[PIXEL_W-1:0];
            end
            send_trans(word);
            if (!pixels_only) begin
                draw_bits(src_lfsr, 1, r);
                if (r[0]) begin
                    next_cycle();
                end
            end
        end
        src_done = 1'b1;
    endtask

    ////////////////////
    // Output sink
    ////////////////////

    task automatic drain_results(input bit slow);
        int          timer;
        int          delay;
        logic [31:0] r;
        while (!abort && !(src_done && n_results == n_pix_sent)) begin
            timer = 0;
            while (!eg_req && !abort && !(src_done && n_results == n_pix_sent)) begin
                next_cycle();
                timer++;
                if (timer > TIMEOUT) begin
                    $display("Timeout at %0t: eg_req never rose for a pending result", $time);
                    timeout_cnt++;
                    abort = 1'b1;
                end
            end
            if (eg_req && !abort) begin
                check_result();
                draw_bits(sink_lfsr, 2, r);
                delay = int'(r[1:0]);
                // Stretch the ack so the result queue backs up
                if (slow) begin
                    delay = delay + 4;
                end
                repeat (delay) next_cycle();
                eg_ack = 1'b1;
                timer  = 0;
                while (eg_req && !abort) begin
                    next_cycle();
                    timer++;
                    if (timer > TIMEOUT) begin
                        $display("Timeout at %0t: eg_req stayed high after eg_ack", $time);
                        timeout_cnt++;
                        abort = 1'b1;
                    end
                end
                eg_ack = 1'b0;
            end
        end
    endtask

    task automatic run_phase(input int count, input bit pixels_only, input bit slow);
        src_done = 1'b0;
        fork
            run_source(count, pixels_only);
            drain_results(slow);
        join
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        int timer;
        in_req       = 1'b0;
        in_data      = '0;
        eg_ack       = 1'b0;
        src_lfsr     = 16'd50;
        sink_lfsr    = 16'd50;
        next_seq     = '0;
        n_pix_sent   = 0;
        n_results    = 0;
        mismatch_cnt = 0;
        timeout_cnt  = 0;
        fail_cnt     = 0;
        src_done     = 1'b0;
        abort        = 1'b0;
        for (int q = 0; q < NUM_QUADS; q++) begin
            model_wt[q] = '0;
        end

        // Reset read on the edge, where it is steady
        timer = 0;
        while (rst !== 1'b0 && !abort) begin
            @(posedge clk_FAS);
            timer++;
            if (timer > TIMEOUT) begin
                $display("Timeout at %0t: reset never released", $time);
                timeout_cnt++;
                abort = 1'b1;
            end
        end
        #1;

        // Quiet ports before any input
        repeat (4) begin
            next_cycle();
            assert (!in_ack) else begin
                $display("MISMATCH at %0t: in_ack expected 0 got %0b", $time, in_ack);
                mismatch_cnt++;
            end
            assert (!eg_req) else begin
                $display("MISMATCH at %0t: eg_req expected 0 got %0b", $time, eg_req);
                mismatch_cnt++;
            end
        end

        // Mixed weights and pixels, then a pixel burst under slow acks
        if (!abort) begin
            run_phase(MIX_COUNT, 1'b0, 1'b0);
        end
        if (!abort) begin
            run_phase(BURST_COUNT, 1'b1, 1'b1);
        end

        // Nothing extra may follow the last result
        repeat (20) begin
            next_cycle();
            assert (abort || !eg_req) else begin
                $display("Extra result seq %0d at %0t after all results", eg_data.seq, $time);
                fail_cnt++;
            end
        end
        assert (abort || n_results == n_pix_sent) else begin
            $display("MISMATCH at %0t: result count expected %0d got %0d",
                     $time, n_pix_sent, n_results);
            mismatch_cnt++;
        end
        assert (abort || exp_q.size() == 0) else begin
            $display("%0d expected results were never delivered", exp_q.size());
            fail_cnt++;
        end

        $display("Results %0d of %0d, mismatches %0d, timeouts %0d, other errors %0d",
                 n_results, n_pix_sent, mismatch_cnt, timeout_cnt, fail_cnt);
        if (mismatch_cnt == 0 && timeout_cnt == 0 && fail_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the accelerator slice testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module tb_cnn_awp \
    -f src.f \
    -o tb_cnn_awp

./obj_dir/tb_cnn_awp | tee sim.log

if grep -qx "Simulation finished: PASS" sim.log; then
    echo "run_sim: testbench passed"
    exit 0
else
    echo "run_sim: testbench failed, see sim.log"
    exit 1
fi

/* src.f */
src/cnn_awp_pkg.sv
src/awp_ingress.sv
src/awp_quad.sv
src/awp_egress.sv
src/cnn_layer_accel_awp.sv
dv/tb_clock_gen.sv
dv/cnn_awp_props.sv
dv/tb_cnn_awp.sv

/* src/awp_egress.sv */
`timescale 1ns/1ps

module awp_egress #(
    parameter int EG_DEPTH = 4
) (
    input  logic                   clk_FAS,
    input  logic                   rst,
    // Final sums from the last quad
    input  logic                   res_valid,
    input  cnn_awp_pkg::sum_t      res_sum,
    output logic                   res_ready,
    // Four-phase output port
    output logic                   eg_req,
    input  logic                   eg_ack,
    output cnn_awp_pkg::trans_eg_t eg_data
);

    import cnn_awp_pkg::*;

    localparam int PTR_W = (EG_DEPTH > 1) ? $clog2(EG_DEPTH) : 1;
    localparam int CNT_W = $clog2(EG_DEPTH + 1);

    egress_state_e state;
    // Result queue
    sum_t          res_mem [EG_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] cnt;
    logic          push;
    logic          pop;
    // Tag of the next result out
    seq_t          seq_r;

    assign res_ready = (cnt != CNT_W'(EG_DEPTH));
    assign push      = res_valid && res_ready;
    // Head leaves once the sink has acked it
    assign pop       = (state == EG_REQ) && eg_ack;

    ////////////////////
    // Result queue
    ////////////////////

    always_ff @(posedge clk_FAS) begin
        if (push) begin
            res_mem[wr_ptr] <= res_sum;
        end
        // Word held steady for the whole req phase
        if (state == EG_IDLE) begin
            eg_data.seq <= seq_r;
            eg_data.sum <= res_mem[rd_ptr];
        end
    end

    always_ff @(posedge clk_FAS) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt    <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(EG_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(EG_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            cnt <= cnt + CNT_W'(push) - CNT_W'(pop);
        end
    end

    ////////////////////
    // Sender FSM
    ////////////////////

    always_ff @(posedge clk_FAS) begin
        if (rst) begin
            state  <= EG_IDLE;
            eg_req <= 1'b0;
            seq_r  <= '0;
        end else begin
            case (state)
                // Previous ack must be low first
                EG_IDLE: begin
                    if (cnt != '0 && !eg_ack) begin
                        eg_req <= 1'b1;
                        state  <= EG_REQ;
                    end
                end
                EG_REQ: begin
                    if (eg_ack) begin
                        eg_req <= 1'b0;
                        seq_r  <= seq_r + 1'b1;
                        state  <= EG_RELEASE;
                    end
                end
                EG_RELEASE: begin
                    if (!eg_ack) begin
                        state <= EG_IDLE;
                    end
                end
                default: state <= EG_IDLE;
            endcase
        end
    end

endmodule

/* src/awp_ingress.sv */
`timescale 1ns/1ps

module awp_ingress #(
    parameter int NUM_QUADS = 4
) (
    input  logic                                  clk_FAS,
    input  logic                                  rst,
    // Four-phase input port
    input  logic                                  in_req,
    input  cnn_awp_pkg::trans_in_t                in_data,
    output logic                                  in_ack,
    // Status gathered from the quads
    input  logic [NUM_QUADS-1:0]                  quad_pix_ready,
    input  logic [NUM_QUADS-1:0]                  quad_idle,
    // Weight broadcast and pixel push, shared lanes
    output logic                                  wt_load,
    output logic                                  pix_valid,
    output cnn_awp_pkg::pixel_t [NUM_QUADS-1:0]   lanes
);

    import cnn_awp_pkg::*;

    ingress_state_e state;
    // Captured input word
    trans_in_t      word_r;
    logic           all_pix_ready;
    logic           all_idle;

    // Every quad must take the vector in the same cycle
    assign all_pix_ready = &quad_pix_ready;
    // Weights change only once the chain is empty
    assign all_idle      = &quad_idle;

    // Lane q of the held word feeds quad q
    always_comb begin
        for (int q = 0; q < NUM_QUADS; q++) begin
            lanes[q] = word_r.lanes[q];
        end
    end

    ////////////////////
    // Capture
    ////////////////////

    // Word is stable while in_req is high
    always_ff @(posedge clk_FAS) begin
        if (state == ING_IDLE && in_req) begin
            word_r <= in_data;
        end
    end

    ////////////////////
    // Handshake FSM
    ////////////////////

    always_ff @(posedge clk_FAS) begin
        if (rst) begin
            state     <= ING_IDLE;
            in_ack    <= 1'b0;
            wt_load   <= 1'b0;
            pix_valid <= 1'b0;
        end else begin
            // Single-cycle pulses
            wt_load   <= 1'b0;
            pix_valid <= 1'b0;
            case (state)
                ING_IDLE: begin
                    if (in_req) begin
                        if (in_data.kind == KIND_PIXEL) begin
                            if (all_pix_ready) begin
                                in_ack    <= 1'b1;
                                pix_valid <= 1'b1;
                                state     <= ING_RELEASE;
                            end else begin
                                state <= ING_HOLD;
                            end
                        end else if (all_idle) begin
                            in_ack  <= 1'b1;
                            wt_load <= 1'b1;
                            state   <= ING_RELEASE;
                        end else begin
                            state <= ING_DRAIN;
                        end
                    end
                end
                // Pixel waits for room in every pixel queue
                ING_HOLD: begin
                    if (all_pix_ready) begin
                        in_ack    <= 1'b1;
                        pix_valid <= 1'b1;
                        state     <= ING_RELEASE;
                    end
                end
                // Weight waits for queued work to finish
                ING_DRAIN: begin
                    if (all_idle) begin
                        in_ack  <= 1'b1;
                        wt_load <= 1'b1;
                        state   <= ING_RELEASE;
                    end
                end
                // Hold ack until the source drops req
                ING_RELEASE: begin
                    if (!in_req) begin
                        in_ack <= 1'b0;
                        state  <= ING_IDLE;
                    end
                end
                default: state <= ING_IDLE;
            endcase
        end
    end

endmodule

/* src/awp_quad.sv */
`timescale 1ns/1ps

module awp_quad #(
    parameter bit FIRST_STAGE = 1'b0,
    parameter int PIX_DEPTH   = 4,
    parameter int CASC_DEPTH  = 4
) (
    input  logic                clk_FAS,
    input  logic                rst,
    // Weight broadcast
    input  logic                wt_load,
    input  cnn_awp_pkg::pixel_t wt_in,
    // Pixel link from ingress
    input  logic                pix_valid,
    input  cnn_awp_pkg::pixel_t pix_in,
    output logic                pix_ready,
    // Cascade from the previous quad
    input  logic                casc_in_valid,
    input  cnn_awp_pkg::sum_t   casc_in_sum,
    output logic                casc_in_ready,
    // Cascade toward the next quad or egress
    output logic                casc_out_valid,
    output cnn_awp_pkg::sum_t   casc_out_sum,
    input  logic                casc_out_ready,
    output logic                idle
);

    import cnn_awp_pkg::*;

    localparam int PIX_PTR_W  = (PIX_DEPTH > 1) ? $clog2(PIX_DEPTH) : 1;
    localparam int PIX_CNT_W  = $clog2(PIX_DEPTH + 1);
    localparam int CASC_PTR_W = (CASC_DEPTH > 1) ? $clog2(CASC_DEPTH) : 1;
    localparam int CASC_CNT_W = $clog2(CASC_DEPTH + 1);

    pixel_t                weight_r;
    // Pixel queue
    pixel_t                pix_mem [PIX_DEPTH];
    logic [PIX_PTR_W-1:0]  pix_wr;
    logic [PIX_PTR_W-1:0]  pix_rd;
    logic [PIX_CNT_W-1:0]  pix_cnt;
    logic                  pix_push;
    // Cascade input queue
    sum_t                  casc_mem [CASC_DEPTH];
    logic [CASC_PTR_W-1:0] casc_wr;
    logic [CASC_PTR_W-1:0] casc_rd;
    logic [CASC_CNT_W-1:0] casc_cnt;
    logic                  casc_push;
    // MAC stage
    logic                  casc_have;
    sum_t                  casc_head;
    logic                  fire;

    assign pix_ready     = (pix_cnt != PIX_CNT_W'(PIX_DEPTH));
    assign casc_in_ready = (casc_cnt != CASC_CNT_W'(CASC_DEPTH));
    assign pix_push      = pix_valid && pix_ready;
    assign casc_push     = casc_in_valid && casc_in_ready;

    // First stage starts the chain from zero
    assign casc_have = FIRST_STAGE ? 1'b1 : (casc_cnt != '0);
    assign casc_head = FIRST_STAGE ? '0 : casc_mem[casc_rd];

    // Output register free or draining this cycle
    assign fire = (pix_cnt != '0) && casc_have && (!casc_out_valid || casc_out_ready);
    assign idle = (pix_cnt == '0) && (casc_cnt == '0) && !casc_out_valid;

    ////////////////////
    // Queue storage
    ////////////////////

    always_ff @(posedge clk_FAS) begin
        if (pix_push) begin
            pix_mem[pix_wr] <= pix_in;
        end
        if (casc_push) begin
            casc_mem[casc_wr] <= casc_in_sum;
        end
        // Product widened to the cascade width before the add
        if (fire) begin
            casc_out_sum <= sum_t'(pix_mem[pix_rd]) * sum_t'(weight_r) + casc_head;
        end
    end

    ////////////////////
    // Control
    ////////////////////

    always_ff @(posedge clk_FAS) begin
        if (rst) begin
            weight_r       <= '0;
            pix_wr         <= '0;
            pix_rd         <= '0;
            pix_cnt        <= '0;
            casc_wr        <= '0;
            casc_rd        <= '0;
            casc_cnt       <= '0;
            casc_out_valid <= 1'b0;
        end else begin
            if (wt_load) begin
                weight_r <= wt_in;
            end
            // Pointers wrap at the queue depth
            if (pix_push) begin
                pix_wr <= (pix_wr == PIX_PTR_W'(PIX_DEPTH - 1)) ? '0 : pix_wr + 1'b1;
            end
            if (fire) begin
                pix_rd <= (pix_rd == PIX_PTR_W'(PIX_DEPTH - 1)) ? '0 : pix_rd + 1'b1;
            end
            pix_cnt <= pix_cnt + PIX_CNT_W'(pix_push) - PIX_CNT_W'(fire);
            if (casc_push) begin
                casc_wr <= (casc_wr == CASC_PTR_W'(CASC_DEPTH - 1)) ? '0 : casc_wr + 1'b1;
            end
            // Cascade head is consumed only past the first stage
            if (fire && !FIRST_STAGE) begin
                casc_rd  <= (casc_rd == CASC_PTR_W'(CASC_DEPTH - 1)) ? '0 : casc_rd + 1'b1;
            end
            casc_cnt <= casc_cnt + CASC_CNT_W'(casc_push)
                        - CASC_CNT_W'(fire && !FIRST_STAGE);
            if (fire) begin
                casc_out_valid <= 1'b1;
            end else if (casc_out_ready) begin
                casc_out_valid <= 1'b0;
            end
        end
    end

endmodule

/* src/cnn_awp_pkg.sv */
package cnn_awp_pkg;

    ////////////////////
    // Widths
    ////////////////////

    // Payload lanes per input transaction, also the quad limit
    localparam int NUM_LANES = 4;
    // Pixel and weight width
    localparam int PIXEL_W   = 8;
    // Room for four unsigned 8x8 products
    localparam int SUM_W     = 18;
    // Result sequence tag
    localparam int SEQ_W     = 8;

    typedef logic [PIXEL_W-1:0] pixel_t;
    typedef logic [SUM_W-1:0]   sum_t;
    typedef logic [SEQ_W-1:0]   seq_t;

    ////////////////////
    // Transactions
    ////////////////////

    typedef enum logic {
        KIND_WEIGHT = 1'b0,
        KIND_PIXEL  = 1'b1
    } trans_kind_e;

    // Input word, lane q goes to quad q
    typedef struct packed {
        trans_kind_e            kind;
        pixel_t [NUM_LANES-1:0] lanes;
    } trans_in_t;

    // Output word
    typedef struct packed {
        seq_t seq;
        sum_t sum;
    } trans_eg_t;

    ////////////////////
    // State machines
    ////////////////////

    typedef enum logic [1:0] {
        ING_IDLE,
        ING_HOLD,
        ING_DRAIN,
        ING_RELEASE
    } ingress_state_e;

    typedef enum logic [1:0] {
        EG_IDLE,
        EG_REQ,
        EG_RELEASE
    } egress_state_e;

endpackage

/* src/cnn_layer_accel_awp.sv */
`timescale 1ns/1ps

module cnn_layer_accel_awp #(
    parameter int NUM_QUADS  = 4,
    parameter int PIX_DEPTH  = 4,
    parameter int CASC_DEPTH = 4,
    parameter int EG_DEPTH   = 4
) (
    input  logic                   clk_FAS,
    input  logic                   rst,
    input  logic                   in_req,
    input  cnn_awp_pkg::trans_in_t in_data,
    output logic                   in_ack,
    output logic                   eg_req,
    output cnn_awp_pkg::trans_eg_t eg_data,
    input  logic                   eg_ack
);

    import cnn_awp_pkg::*;

    logic [NUM_QUADS-1:0]   quad_pix_ready;
    logic [NUM_QUADS-1:0]   quad_idle;
    logic                   wt_load;
    logic                   pix_valid;
    pixel_t [NUM_QUADS-1:0] lanes;
    // Cascade link k enters quad k, link NUM_QUADS goes to egress
    logic [NUM_QUADS:0]     casc_valid;
    logic [NUM_QUADS:0]     casc_ready;
    sum_t [NUM_QUADS:0]     casc_sum;

    // Nothing feeds the head of the chain
    assign casc_valid[0] = 1'b0;
    assign casc_sum[0]   = '0;

    awp_ingress #(
        .NUM_QUADS (NUM_QUADS)
    ) i_awp_ingress (
        .clk_FAS        (clk_FAS),
        .rst            (rst),
        .in_req         (in_req),
        .in_data        (in_data),
        .in_ack         (in_ack),
        .quad_pix_ready (quad_pix_ready),
        .quad_idle      (quad_idle),
        .wt_load        (wt_load),
        .pix_valid      (pix_valid),
        .lanes          (lanes)
    );

    ////////////////////
    // Quad chain
    ////////////////////

    for (genvar k = 0; k < NUM_QUADS; k++) begin : quad
        awp_quad #(
            .FIRST_STAGE (k == 0),
            .PIX_DEPTH   (PIX_DEPTH),
            .CASC_DEPTH  (CASC_DEPTH)
        ) i_awp_quad (
            .clk_FAS        (clk_FAS),
            .rst            (rst),
            .wt_load        (wt_load),
            .wt_in          (lanes[k]),
            .pix_valid      (pix_valid),
            .pix_in         (lanes[k]),
            .pix_ready      (quad_pix_ready[k]),
            .casc_in_valid  (casc_valid[k]),
            .casc_in_sum    (casc_sum[k]),
            .casc_in_ready  (casc_ready[k]),
            .casc_out_valid (casc_valid[k+1]),
            .casc_out_sum   (casc_sum[k+1]),
            .casc_out_ready (casc_ready[k+1]),
            .idle           (quad_idle[k])
        );
    end

    // Last quad drains into the result queue
    awp_egress #(
        .EG_DEPTH (EG_DEPTH)
    ) i_awp_egress (
        .clk_FAS   (clk_FAS),
        .rst       (rst),
        .res_valid (casc_valid[NUM_QUADS]),
        .res_sum   (casc_sum[NUM_QUADS]),
        .res_ready (casc_ready[NUM_QUADS]),
        .eg_req    (eg_req),
        .eg_ack    (eg_ack),
        .eg_data   (eg_data)
    );

endmodule
